/* source/isa_pkg.sv */
////////////////////////////////////////
// ISA definitions for the 16-bit CPU
// Word widths, opcodes and field access
////////////////////////////////////////
package isa_pkg;

  localparam int ADDR_W   = 16;  // Word address width
  localparam int INST_W   = 16;  // Instruction word width
  localparam int OPCODE_W = 4;   // Top field of every instruction
  localparam int BR_OFF_W = 8;   // Signed branch displacement

  typedef logic [ADDR_W-1:0]          addr_t;
  typedef logic [INST_W-1:0]          inst_t;
  typedef logic [OPCODE_W-1:0]        opcode_t;
  typedef logic signed [BR_OFF_W-1:0] br_offset_t;

  localparam opcode_t OP_NOP  = 4'h0;  // All-zero word does nothing
  localparam opcode_t OP_BR   = 4'hC;  // Conditional branch, PC + 1 + offset
  localparam opcode_t OP_HALT = 4'hF;  // Stops fetch

  // Opcode sits in the top bits
  function automatic opcode_t opcode_of(inst_t inst);
    return inst[INST_W-1 -: OPCODE_W];
  endfunction

  // Branch offset sits in the low bits
  function automatic br_offset_t br_offset_of(inst_t inst);
    return br_offset_t'(inst[BR_OFF_W-1:0]);
  endfunction

endpackage

/* source/frontend_pkg.sv */
////////////////////////////////////////
// Front-end microarchitecture package
// Predictor and memory sizes, plus the
// structs passed between fetch blocks
////////////////////////////////////////
package frontend_pkg;

  localparam int PRED_DEPTH  = 16;   // Counter table entries
  localparam int PRED_IDX_W  = 4;    // Low PC bits index the table
  localparam int IMEM_DEPTH  = 256;  // Instruction memory words
  localparam int IMEM_ADDR_W = 8;

  typedef logic [1:0]             pred_t;       // MSB set = predict taken
  typedef logic [PRED_IDX_W-1:0]  pc_tag_t;
  typedef logic [IMEM_ADDR_W-1:0] imem_addr_t;

  localparam pred_t PRED_RESET = 2'b01;  // Weakly not taken
  localparam pred_t PRED_MAX   = 2'b11;  // Strongly taken
  localparam pred_t PRED_MIN   = 2'b00;  // Strongly not taken

  // What fetch produces each cycle
  typedef struct packed {
    isa_pkg::addr_t pc_curr;
    isa_pkg::addr_t pc_next;     // Fall-through address
    isa_pkg::inst_t inst;
    pred_t          prediction;
  } fetch_t;

  // What decode sees
  typedef struct packed {
    pc_tag_t        pc_tag;      // Low PC bits only
    isa_pkg::addr_t pc_next;
    isa_pkg::inst_t inst;
    pred_t          prediction;
  } if_id_t;

  // Branch outcome coming back from execute
  typedef struct packed {
    pc_tag_t        index;       // Predictor entry to train
    logic           taken;
    logic           mispredict;
    isa_pkg::addr_t target;      // Recovery PC
  } resolve_t;

  // Program load port
  typedef struct packed {
    imem_addr_t     addr;
    isa_pkg::inst_t data;
  } imem_wr_t;

  typedef enum logic {
    RUN,
    HALTED
  } fe_state_t;

endpackage

/* source/instr_mem.sv */
////////////////////////////////////////
// 256-word instruction memory
// Async read and a sync load port
////////////////////////////////////////
`timescale 1ns/1ps

module instr_mem (
  input  logic                   clk,
  input  isa_pkg::addr_t         pc,    // Fetch address
  output isa_pkg::inst_t         inst,  // Word at pc
  input  logic                   we,    // Load strobe
  input  frontend_pkg::imem_wr_t wr     // Load address and data
);

  import isa_pkg::*;
  import frontend_pkg::*;

  inst_t      mem [IMEM_DEPTH];  // Program words from the load port
  imem_addr_t rd_addr;

  assign rd_addr = pc[IMEM_ADDR_W-1:0];  // Upper PC bits alias
  assign inst    = mem[rd_addr];

  // Each strobe loads one word that the read sees next cycle
  always_ff @(posedge clk) begin
    if (we) begin
      mem[wr.addr] <= wr.data;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // A load with X address would corrupt an unknown word
  a_wr_addr_known: assert property (
    @(posedge clk) we |-> !$isunknown(wr.addr)
  ) else $error("instr_mem: write address has unknown bits");

endmodule

/* source/branch_predictor.sv */
////////////////////////////////////////
// Branch predictor
// 16 x 2-bit saturating counters, read
// by fetch PC, trained on resolve
////////////////////////////////////////
`timescale 1ns/1ps

module branch_predictor (
  input  logic                   clk,
  input  logic                   rst,
  input  isa_pkg::addr_t         pc,          // Fetch address
  output frontend_pkg::pred_t    prediction,  // Counter for pc
  input  logic                   update,      // Resolve strobe
  input  frontend_pkg::resolve_t resolve      // Outcome from execute
);

  import isa_pkg::*;
  import frontend_pkg::*;

  pred_t   ctr [PRED_DEPTH];  // Counter table
  pc_tag_t rd_idx;

  // Lookup
  assign rd_idx     = pc[PRED_IDX_W-1:0];
  assign prediction = ctr[rd_idx];

  // Training, saturating at both ends
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < PRED_DEPTH; i++) begin
        ctr[i] <= PRED_RESET;
      end
    end else if (update) begin
      if (resolve.taken) begin
        if (ctr[resolve.index] != PRED_MAX) ctr[resolve.index] <= ctr[resolve.index] + 2'd1;
      end else begin
        if (ctr[resolve.index] != PRED_MIN) ctr[resolve.index] <= ctr[resolve.index] - 2'd1;
      end
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Taken never lowers a counter, not-taken never raises it
  a_no_wrap: assert property (
    @(posedge clk) disable iff (rst)
    update |=> ($past(resolve.taken) ? ctr[$past(resolve.index)] >= $past(ctr[resolve.index])
                                     : ctr[$past(resolve.index)] <= $past(ctr[resolve.index]))
  ) else $error("branch_predictor: counter wrapped");

endmodule

/* source/pc_unit.sv */
////////////////////////////////////////
// Program counter unit
// PC register, next-PC select and the
// static branch target adder
////////////////////////////////////////
`timescale 1ns/1ps

module pc_unit (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 pc_en,        // Advance or load the PC
  input  logic                 redirect,     // Take redirect_pc
  input  isa_pkg::addr_t       redirect_pc,  // Recovery target
  input  isa_pkg::inst_t       inst,         // Word fetched at pc
  input  frontend_pkg::pred_t  prediction,   // Counter fetched at pc
  output isa_pkg::addr_t       pc,
  output frontend_pkg::fetch_t fetch         // Bundle for IF/ID
);

  import isa_pkg::*;
  import frontend_pkg::*;

  addr_t pc_q;
  addr_t pc_plus1;    // Fall-through
  addr_t br_target;   // PC + 1 + sext(offset)
  addr_t pc_d;
  logic  pred_taken;  // Fetched branch predicted taken

  assign pc_plus1   = pc_q + addr_t'(1);
  assign br_target  = pc_plus1 + addr_t'(br_offset_of(inst));  // Sign extended by cast
  assign pred_taken = (opcode_of(inst) == OP_BR) && prediction[1];

  // Priority: redirect, then predicted target, then fall-through
  always_comb begin
    if (redirect)        pc_d = redirect_pc;
    else if (pred_taken) pc_d = br_target;
    else                 pc_d = pc_plus1;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= '0;  // Fetch starts at word 0
    end else if (pc_en) begin
      pc_q <= pc_d;
    end
  end

  assign pc = pc_q;

  // Fetch bundle
  assign fetch.pc_curr    = pc_q;
  assign fetch.pc_next    = pc_plus1;  // Decode needs fall-through for recovery
  assign fetch.inst       = inst;
  assign fetch.prediction = prediction;

endmodule

/* source/fetch_control.sv */
////////////////////////////////////////
// Fetch control
// Run/halt FSM plus stall, flush and
// redirect decisions
////////////////////////////////////////
`timescale 1ns/1ps

module fetch_control (
  input  logic             clk,
  input  logic             rst,
  input  logic             stall,        // Decode hazard
  input  logic             mispredict,   // Qualified resolve mispredict
  input  isa_pkg::opcode_t opcode,       // Opcode of the fetched word
  output logic             pc_en,
  output logic             redirect,
  output logic             if_id_en,
  output logic             if_id_flush,
  output logic             halted
);

  import isa_pkg::*;
  import frontend_pkg::*;

  fe_state_t state, state_nxt;

  always_comb begin
    pc_en       = 1'b0;
    redirect    = 1'b0;
    if_id_en    = 1'b0;
    if_id_flush = 1'b0;
    state_nxt   = state;
    if (mispredict) begin     // Overrides stall and halt
      redirect    = 1'b1;
      pc_en       = 1'b1;
      if_id_flush = 1'b1;
      state_nxt   = RUN;
    end else if (!stall) begin  // Stall holds everything
      case (state)
        RUN: begin
          pc_en    = 1'b1;
          if_id_en = 1'b1;    // HALT word still enters IF/ID
          if (opcode == OP_HALT) state_nxt = HALTED;
        end
        HALTED:  if_id_flush = 1'b1;  // Feed no-ops
        default: state_nxt = RUN;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) state <= RUN;
    else     state <= state_nxt;
  end

  assign halted = (state == HALTED);

  // Recovery bubbles IF/ID and always leaves halt
  a_redirect_flush: assert property (
    @(posedge clk) disable iff (rst)
    redirect |-> (if_id_flush && !if_id_en) ##1 !halted
  ) else $error("fetch_control: redirect without flush or resume");

endmodule

/* source/if_id_pipe_reg.sv */
////////////////////////////////////////
// IF/ID pipeline register
// Holds on stall, bubbles on flush
////////////////////////////////////////
`timescale 1ns/1ps

module if_id_pipe_reg (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 en,     // Load from fetch
  input  logic                 flush,  // Clear inst and prediction
  input  frontend_pkg::fetch_t fetch,
  output frontend_pkg::if_id_t if_id
);

  import isa_pkg::*;
  import frontend_pkg::*;

  if_id_t q;

  //////////////////////////////////////
  // Address fields, kept across flush
  //////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      q.pc_tag  <= '0;
      q.pc_next <= '0;
    end else if (en) begin
      q.pc_tag  <= fetch.pc_curr[PRED_IDX_W-1:0];  // Predictor index only
      q.pc_next <= fetch.pc_next;
    end
  end

  //////////////////////////////////////
  // Payload, cleared to a no-op
  //////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      q.inst       <= {OP_NOP, {(INST_W-OPCODE_W){1'b0}}};
      q.prediction <= '0;
    end else if (en) begin
      q.inst       <= fetch.inst;
      q.prediction <= fetch.prediction;
    end
  end

  assign if_id = q;

endmodule

/* source/cpu_frontend.sv */
////////////////////////////////////////
// CPU front end
// Fetch datapath, predictor and control
// feeding the IF/ID register
////////////////////////////////////////
`timescale 1ns/1ps

module cpu_frontend (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   imem_we,        // Program load strobe
  input  frontend_pkg::imem_wr_t imem_wr,
  input  logic                   stall,          // Hazard from decode
  input  logic                   resolve_valid,  // One-cycle strobe from execute
  input  frontend_pkg::resolve_t resolve,
  output frontend_pkg::if_id_t   if_id,
  output logic                   halted
);

  import isa_pkg::*;
  import frontend_pkg::*;

  addr_t  pc;
  inst_t  inst;
  pred_t  prediction;
  fetch_t fetch;
  logic   pc_en, redirect;
  logic   if_id_en, if_id_flush;

  instr_mem instr_mem_i (
    .clk  (clk),
    .pc   (pc),
    .inst (inst),
    .we   (imem_we),
    .wr   (imem_wr)
  );

  branch_predictor branch_predictor_i (
    .clk        (clk),
    .rst        (rst),
    .pc         (pc),
    .prediction (prediction),
    .update     (resolve_valid),
    .resolve    (resolve)
  );

  pc_unit pc_unit_i (
    .clk         (clk),
    .rst         (rst),
    .pc_en       (pc_en),
    .redirect    (redirect),
    .redirect_pc (resolve.target),
    .inst        (inst),
    .prediction  (prediction),
    .pc          (pc),
    .fetch       (fetch)
  );

  fetch_control fetch_control_i (
    .clk         (clk),
    .rst         (rst),
    .stall       (stall),
    .mispredict  (resolve_valid & resolve.mispredict),  // Only on the strobe
    .opcode      (opcode_of(inst)),
    .pc_en       (pc_en),
    .redirect    (redirect),
    .if_id_en    (if_id_en),
    .if_id_flush (if_id_flush),
    .halted      (halted)
  );

  if_id_pipe_reg if_id_pipe_reg_i (
    .clk   (clk),
    .rst   (rst),
    .en    (if_id_en),
    .flush (if_id_flush),
    .fetch (fetch),
    .if_id (if_id)
  );

endmodule

/* verification/tb_cpu_frontend.sv */
////////////////////////////////////////
// Testbench for the CPU front end
// Directed tests against a cycle model
// of PC, IF/ID, halt state and counters
////////////////////////////////////////
`timescale 1ns/1ps

module tb_cpu_frontend;

  import isa_pkg::*;
  import frontend_pkg::*;

  localparam int CLK_PERIOD = 10;
  // Load, reset, sequential, predictor, stall, mispredict, halt
  localparam int CYCLE_BUDGET = 260 + 2 + 20 + 15 + 10 + 6 + 12;
  localparam resolve_t NO_RES = '0;

  logic     clk, rst, imem_we, stall, resolve_valid, halted;
  imem_wr_t imem_wr;
  resolve_t resolve;
  if_id_t   if_id;

  // Reference state
  inst_t       img [IMEM_DEPTH];  // Mirror of instruction memory
  pred_t       ctr_m [PRED_DEPTH];
  addr_t       pc_m;
  logic        halted_m;
  if_id_t      ifid_m;
  logic [31:0] rng_state;

  cpu_frontend cpu_frontend_i (
    .clk           (clk),
    .rst           (rst),
    .imem_we       (imem_we),
    .imem_wr       (imem_wr),
    .stall         (stall),
    .resolve_valid (resolve_valid),
    .resolve       (resolve),
    .if_id         (if_id),
    .halted        (halted)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic abort_run();
    $display("Regression failed");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_if_id(input if_id_t exp, input string what);
    if (if_id !== exp) begin
      $display("MISMATCH at %0t: %s, if_id %h expected %h", $time, what, if_id, exp);
      abort_run();
    end
  endtask

  task automatic check_halted(input logic exp, input string what);
    if (halted !== exp) begin
      $display("MISMATCH at %0t: %s, halted %b expected %b", $time, what, halted, exp);
      abort_run();
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Any opcode but branch or halt
  function automatic inst_t filler_word(input logic [31:0] r);
    inst_t w;
    w = r[15:0];
    if (w[15:12] == OP_BR || w[15:12] == OP_HALT) w[15] = 1'b0;  // C->4, F->7
    return w;
  endfunction

  // 2-bit saturating counter rule
  function automatic pred_t train_counter(input pred_t c, input logic taken);
    if (taken) return (c == 2'b11) ? c : c + 2'd1;
    return (c == 2'b00) ? c : c - 2'd1;
  endfunction

  function automatic resolve_t make_resolve(input pc_tag_t idx, input logic tk,
                                            input logic mp, input addr_t tgt);
    resolve_t r;
    r.index      = idx;
    r.taken      = tk;
    r.mispredict = mp;
    r.target     = tgt;
    return r;
  endfunction

  // Drives one clock of inputs, advances the model and checks after the edge
  task automatic step(input logic stall_in, input logic rv_in, input resolve_t res_in);
    inst_t w;
    pred_t p;
    w = img[pc_m[7:0]];
    p = ctr_m[pc_m[3:0]];  // Lookup sees the counter before this cycle's update
    stall         = stall_in;
    resolve_valid = rv_in;
    resolve       = res_in;
    if (rv_in && res_in.mispredict) begin  // Recovery wins over all
      ifid_m.inst       = '0;
      ifid_m.prediction = '0;
      pc_m              = res_in.target;
      halted_m          = 1'b0;
    end else if (!stall_in && !halted_m) begin
      ifid_m = '{pc_m[3:0], pc_m + 16'd1, w, p};
      if (w[15:12] == OP_BR && p[1]) pc_m = pc_m + 16'd1 + {{8{w[7]}}, w[7:0]};
      else pc_m = pc_m + 16'd1;
      if (w[15:12] == OP_HALT) halted_m = 1'b1;
    end else if (!stall_in) begin  // Halted so IF/ID gets bubbles
      ifid_m.inst       = '0;
      ifid_m.prediction = '0;
    end
    if (rv_in) ctr_m[res_in.index] = train_counter(ctr_m[res_in.index], res_in.taken);
    @(posedge clk);
    #1;
    check_if_id(ifid_m, "cycle model");
    check_halted(halted_m, "cycle model");
  endtask

  // Write while stalled so the word is seen next cycle
  task automatic load_word(input imem_addr_t a, input inst_t d);
    imem_we = 1'b1;
    imem_wr = '{a, d};
    step(1'b1, 1'b0, NO_RES);
    imem_we = 1'b0;
    img[a]  = d;
  endtask

  task automatic load_program();
    for (int a = 0; a < IMEM_DEPTH; a++) begin
      rng_state = xorshift32(rng_state);
      load_word(imem_addr_t'(a), filler_word(rng_state));
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic test_reset_state();
    if_id_t exp;
    check_if_id('0, "after reset");
    check_halted(1'b0, "after reset");
    step(1'b0, 1'b0, NO_RES);
    exp = '{4'h0, 16'd1, img[0], PRED_RESET};  // Word 0 lands one edge later
    check_if_id(exp, "first fetch");
  endtask

  task automatic test_sequential_fetch();
    if_id_t exp;
    addr_t  pc_exp;
    pc_exp = 16'd1;
    for (int i = 0; i < 20; i++) begin
      step(1'b0, 1'b0, NO_RES);
      exp = '{pc_exp[3:0], pc_exp + 16'd1, img[pc_exp[7:0]], PRED_RESET};
      check_if_id(exp, "sequential fetch");
      pc_exp = pc_exp + 16'd1;
    end
  endtask

  task automatic test_predictor_training();
    if_id_t exp;
    load_word(8'd40, 16'hC005);  // Branch at 40 (index 8) with target 46
    repeat (3) step(1'b1, 1'b1, make_resolve(4'd8, 1'b1, 1'b0, 16'd0));  // Third saturates
    step(1'b1, 1'b1, make_resolve(4'd8, 1'b1, 1'b1, 16'd40));  // Jump back to the branch
    step(1'b0, 1'b0, NO_RES);
    exp = '{4'd8, 16'd41, 16'hC005, 2'b11};
    check_if_id(exp, "branch fetched strongly taken");
    step(1'b0, 1'b0, NO_RES);
    exp = '{4'd14, 16'd47, img[46], PRED_RESET};  // Followed the predicted target
    check_if_id(exp, "predicted target");
    repeat (4) step(1'b1, 1'b1, make_resolve(4'd8, 1'b0, 1'b0, 16'd0));
    step(1'b1, 1'b1, make_resolve(4'd8, 1'b0, 1'b1, 16'd40));
    step(1'b0, 1'b0, NO_RES);
    exp = '{4'd8, 16'd41, 16'hC005, 2'b00};  // Floor at zero
    check_if_id(exp, "branch fetched strongly not taken");
    step(1'b0, 1'b0, NO_RES);
    exp = '{4'd9, 16'd42, img[41], PRED_RESET};
    check_if_id(exp, "fall-through after branch");
  endtask

  task automatic test_stall_hold();
    if_id_t held;
    if_id_t exp;
    addr_t  pc_hold;
    repeat (3) step(1'b0, 1'b0, NO_RES);
    held    = ifid_m;
    pc_hold = pc_m;
    repeat (5) begin
      step(1'b1, 1'b0, NO_RES);
      check_if_id(held, "held under stall");
    end
    step(1'b0, 1'b0, NO_RES);
    exp = '{pc_hold[3:0], pc_hold + 16'd1, img[pc_hold[7:0]], ctr_m[pc_hold[3:0]]};
    check_if_id(exp, "resume from held PC");
  endtask

  task automatic test_mispredict_flush();
    if_id_t exp;
    exp = ifid_m;
    step(1'b0, 1'b1, make_resolve(4'd3, 1'b0, 1'b1, 16'd100));
    exp.inst       = '0;
    exp.prediction = '0;
    check_if_id(exp, "flush without stall");
    step(1'b0, 1'b0, NO_RES);
    exp = '{4'd4, 16'd101, img[100], PRED_RESET};
    check_if_id(exp, "fetch at resolve target");
    step(1'b1, 1'b1, make_resolve(4'd3, 1'b0, 1'b1, 16'd201));  // Beats the stall
    exp.inst       = '0;
    exp.prediction = '0;
    check_if_id(exp, "flush under stall");
    step(1'b1, 1'b0, NO_RES);
    check_if_id(exp, "bubble held by stall");
    step(1'b0, 1'b0, NO_RES);
    exp = '{4'd9, 16'd202, img[201], PRED_RESET};
    check_if_id(exp, "fetch at target after stall");
  endtask

  task automatic test_halt_restart();
    if_id_t exp;
    load_word(8'd120, 16'hF000);
    step(1'b1, 1'b1, make_resolve(4'd5, 1'b0, 1'b1, 16'd118));
    repeat (3) step(1'b0, 1'b0, NO_RES);  // 118, 119, then HALT
    exp = '{4'd8, 16'd121, 16'hF000, ctr_m[8]};
    check_if_id(exp, "halt word in IF/ID");
    check_halted(1'b1, "halt entered");
    exp.inst       = '0;
    exp.prediction = '0;
    repeat (3) begin
      step(1'b0, 1'b0, NO_RES);
      check_if_id(exp, "no-ops while halted");
      check_halted(1'b1, "still halted");
    end
    step(1'b0, 1'b1, make_resolve(4'd5, 1'b0, 1'b1, 16'd130));
    check_halted(1'b0, "restart clears halt");
    step(1'b0, 1'b0, NO_RES);
    exp = '{4'd2, 16'd131, img[130], PRED_RESET};
    check_if_id(exp, "fetch after restart");
  endtask

  ////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////

  initial begin
    #(CYCLE_BUDGET * 10 * CLK_PERIOD);
    $display("Timeout: tests ran past their cycle budget");
    abort_run();
  end

  initial begin
    rst           = 1'b1;
    stall         = 1'b1;  // Hold fetch at 0 while the program loads
    imem_we       = 1'b0;
    imem_wr       = '0;
    resolve_valid = 1'b0;
    resolve       = NO_RES;
    rng_state     = 32'd75784;
    pc_m          = '0;
    halted_m      = 1'b0;
    ifid_m        = '0;
    for (int i = 0; i < PRED_DEPTH; i++) ctr_m[i] = PRED_RESET;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    load_program();
    test_reset_state();
    test_sequential_fetch();
    test_predictor_training();
    test_stall_hold();
    test_mispredict_flush();
    test_halt_restart();
    $display("Regression passed");
    $finish;
  end

endmodule

/* list.f */
source/isa_pkg.sv
source/frontend_pkg.sv
source/instr_mem.sv
source/branch_predictor.sv
source/pc_unit.sv
source/fetch_control.sv
source/if_id_pipe_reg.sv
source/cpu_frontend.sv
verification/tb_cpu_frontend.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the CPU front-end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f list.f --top-module tb_cpu_frontend -o sim_tb_cpu_frontend

# Keep the output even when the simulation exits with an error
output=$(./obj_dir/sim_tb_cpu_frontend 2>&1 || true)
echo "$output"

if echo "$output" | grep -q "Regression passed"; then
  exit 0
else
  exit 1
fi
